//--- logic/i2c_slave_defines.svh
`ifndef I2C_SLAVE_DEFINES_SVH
`define I2C_SLAVE_DEFINES_SVH

// 7-bit address the slave answers to
`define I2C_DEV_ADDR 7'h66

// Size of the register file
`define REG_COUNT 16

// Host address and data fields in the register file
`define WADDR_BASE 0   // Write address, regs 0-3
`define WDATA_BASE 4   // Write data, regs 4-7
`define RADDR_BASE 8   // Read address, regs 8-11
`define RDATA_BASE 12  // Read data, regs 12-15

// Data bits in one I2C byte, the ACK slot follows
`define BYTE_BITS 8

`endif

//--- logic/i2c_slave_pkg.sv
package i2c_slave_pkg;

    typedef logic [7:0] byte_t;      // One bus byte or register
    typedef logic [3:0] reg_ptr_t;   // Register index
    typedef logic [31:0] word_t;     // Host address or data word
    typedef logic [3:0] bit_cnt_t;   // Position in a 9-bit frame

    // Protocol states of the slave
    typedef enum logic [2:0] {
        IDLE,
        START,
        CTRL,     // Address and direction byte
        PTR,      // Register pointer byte
        WR_DATA,
        RD_DATA,
        STOP
    } slave_state_t;

endpackage

//--- logic/i2c_line_monitor.sv
`timescale 1ns/10ps

module i2c_line_monitor (
    input  logic Clk,
    input  logic Rst_n,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl_rise_o,
    output logic scl_fall_o,
    output logic scl_high_o,
    output logic start_det_o,
    output logic stop_det_o,
    output logic sda_bit_o
);

    logic [1:0] scl_sync_q;  // Two-stage synchronizers
    logic [1:0] sda_sync_q;
    logic       scl_q;       // Previous synchronized levels
    logic       sda_q;
    logic       bit_ok_q;    // SDA stayed high through SCL high
    logic       scl_s;
    logic       sda_s;

    assign scl_s = scl_sync_q[1];
    assign sda_s = sda_sync_q[1];

    // Idle bus is high, so no false edges come out of reset
    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            scl_sync_q <= 2'b11;
            sda_sync_q <= 2'b11;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
        end else begin
            scl_sync_q <= {scl_sync_q[0], scl_i};
            sda_sync_q <= {sda_sync_q[0], sda_i};
            scl_q      <= scl_s;
            sda_q      <= sda_s;
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            bit_ok_q <= 1'b0;
        end else if (scl_rise_o) begin
            bit_ok_q <= sda_s;          // Fresh bit starts here
        end else if (scl_s && !sda_s) begin
            bit_ok_q <= 1'b0;           // Any low sample spoils the 1
        end
    end

    assign scl_rise_o  = scl_s & ~scl_q;
    assign scl_fall_o  = ~scl_s & scl_q;
    assign scl_high_o  = scl_s;
    // SDA may only move with SCL low, except for start and stop
    assign start_det_o = scl_s & scl_q & sda_q & ~sda_s;
    assign stop_det_o  = scl_s & scl_q & ~sda_q & sda_s;
    assign sda_bit_o   = bit_ok_q;     // Read by the FSM on scl_fall

endmodule

//--- logic/i2c_slave_fsm.sv
`timescale 1ns/10ps
`include "i2c_slave_defines.svh"

module i2c_slave_fsm
    import i2c_slave_pkg::*;
(
    input  logic         Clk,
    input  logic         Rst_n,
    input  logic         scl_rise_i,
    input  logic         scl_fall_i,
    input  logic         scl_high_i,
    input  logic         start_det_i,
    input  logic         stop_det_i,
    input  logic         sda_bit_i,
    input  byte_t        rd_byte_i,
    output logic         sda_oe_o,
    output logic         sda_o,
    output logic         wr_en_o,
    output reg_ptr_t     wr_ptr_o,
    output byte_t        wr_byte_o,
    output reg_ptr_t     rd_ptr_o
);

    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(`BYTE_BITS - 1);
    localparam bit_cnt_t ACK_SLOT = bit_cnt_t'(`BYTE_BITS);

    slave_state_t state_q;
    bit_cnt_t     bit_cnt_q;   // SCL falls seen in this frame
    byte_t        shift_q;     // Received byte or byte being sent
    reg_ptr_t     ptr_q;
    logic         sda_oe_q;
    logic         sda_q;
    logic         rise_seen_q; // One clock after an SCL rise
    logic         addr_match;
    logic         rx_state;
    logic         rd_load;
    logic         rx_shift;
    logic         tx_shift;

    assign addr_match = (shift_q[6:0] == `I2C_DEV_ADDR);
    assign rx_state   = (state_q == CTRL) || (state_q == PTR) || (state_q == WR_DATA);

    // New read byte at the end of the address ACK or of an acked read byte
    assign rd_load  = scl_fall_i && (bit_cnt_q == ACK_SLOT) &&
                      ((state_q == CTRL && shift_q[0]) || state_q == RD_DATA);
    assign rx_shift = scl_fall_i && rx_state && (bit_cnt_q < ACK_SLOT);
    assign tx_shift = scl_fall_i && (state_q == RD_DATA) && (bit_cnt_q < LAST_BIT);

    always_ff @(posedge Clk) begin
        if (rd_load) begin
            shift_q <= rd_byte_i;
        end else if (rx_shift) begin
            shift_q <= {shift_q[6:0], sda_bit_i};   // MSB first
        end else if (tx_shift) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            state_q     <= IDLE;
            bit_cnt_q   <= '0;
            ptr_q       <= '0;
            sda_oe_q    <= 1'b0;
            sda_q       <= 1'b0;
            rise_seen_q <= 1'b0;
        end else begin
            rise_seen_q <= scl_rise_i;
            if (stop_det_i) begin
                state_q  <= IDLE;
                sda_oe_q <= 1'b0;
                sda_q    <= 1'b0;
            end else if (start_det_i && state_q != IDLE) begin
                state_q  <= START;          // Repeated start keeps the pointer
                sda_oe_q <= 1'b0;
                sda_q    <= 1'b0;
            end else begin
                case (state_q)
                    IDLE: begin
                        if (start_det_i) begin
                            state_q <= START;
                        end
                    end
                    START: begin
                        if (scl_fall_i) begin
                            state_q   <= CTRL;
                            bit_cnt_q <= '0;
                        end
                    end
                    CTRL: begin
                        if (scl_fall_i) begin
                            if (bit_cnt_q == LAST_BIT) begin
                                if (addr_match) begin
                                    sda_oe_q  <= 1'b1;   // ACK
                                    bit_cnt_q <= ACK_SLOT;
                                end else begin
                                    state_q <= IDLE;     // Not for us, stay off the bus
                                end
                            end else if (bit_cnt_q == ACK_SLOT) begin
                                bit_cnt_q <= '0;
                                if (shift_q[0]) begin
                                    state_q  <= RD_DATA;
                                    sda_oe_q <= ~rd_byte_i[7];
                                    sda_q    <= rd_byte_i[7];
                                    ptr_q    <= ptr_q + reg_ptr_t'(1);
                                end else begin
                                    state_q  <= PTR;
                                    sda_oe_q <= 1'b0;
                                end
                            end else begin
                                bit_cnt_q <= bit_cnt_q + bit_cnt_t'(1);
                            end
                        end
                    end
                    PTR, WR_DATA: begin
                        if (scl_fall_i) begin
                            if (bit_cnt_q == LAST_BIT) begin
                                sda_oe_q  <= 1'b1;
                                bit_cnt_q <= ACK_SLOT;
                            end else if (bit_cnt_q == ACK_SLOT) begin
                                sda_oe_q  <= 1'b0;
                                bit_cnt_q <= '0;
                                if (state_q == PTR) begin
                                    ptr_q   <= shift_q[3:0];
                                    state_q <= WR_DATA;
                                end else begin
                                    ptr_q <= ptr_q + reg_ptr_t'(1);  // Byte stored this cycle
                                end
                            end else begin
                                bit_cnt_q <= bit_cnt_q + bit_cnt_t'(1);
                            end
                        end
                    end
                    RD_DATA: begin
                        if (rise_seen_q && scl_high_i && bit_cnt_q == ACK_SLOT &&
                            sda_bit_i) begin
                            state_q <= STOP;     // Master NACK ends the read
                        end else if (scl_fall_i) begin
                            if (bit_cnt_q == LAST_BIT) begin
                                sda_oe_q  <= 1'b0;   // Master's ACK slot
                                sda_q     <= 1'b0;
                                bit_cnt_q <= ACK_SLOT;
                            end else if (bit_cnt_q == ACK_SLOT) begin
                                sda_oe_q  <= ~rd_byte_i[7];
                                sda_q     <= rd_byte_i[7];
                                ptr_q     <= ptr_q + reg_ptr_t'(1);
                                bit_cnt_q <= '0;
                            end else begin
                                sda_oe_q  <= ~shift_q[6];
                                sda_q     <= shift_q[6];
                                bit_cnt_q <= bit_cnt_q + bit_cnt_t'(1);
                            end
                        end
                    end
                    STOP: begin
                        sda_oe_q <= 1'b0;            // Wait for stop or repeated start
                        sda_q    <= 1'b0;
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // Store at the fall that closes the ACK slot
    assign wr_en_o   = scl_fall_i && (state_q == WR_DATA) && (bit_cnt_q == ACK_SLOT);
    assign wr_ptr_o  = ptr_q;
    assign wr_byte_o = shift_q;
    assign rd_ptr_o  = ptr_q;
    assign sda_oe_o  = sda_oe_q;
    assign sda_o     = sda_q;

endmodule

//--- logic/slave_reg_file.sv
`timescale 1ns/10ps
`include "i2c_slave_defines.svh"

module slave_reg_file
    import i2c_slave_pkg::*;
(
    input  logic                        Clk,
    input  logic                        Rst_n,
    input  logic                        wr_en_i,
    input  reg_ptr_t                    wr_ptr_i,
    input  byte_t                       wr_byte_i,
    input  reg_ptr_t                    rd_ptr_i,
    input  logic                        ld_en_i,
    input  word_t                       ld_word_i,
    output byte_t                       rd_byte_o,
    output byte_t [`REG_COUNT-1:0]      regs_o,
    output logic                        wr_done_o,
    output reg_ptr_t                    wr_done_ptr_o
);

    byte_t [`REG_COUNT-1:0] regs_q;

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            regs_q        <= '0;
            wr_done_o     <= 1'b0;
            wr_done_ptr_o <= '0;
        end else begin
            if (ld_en_i) begin
                for (int i = 0; i < 4; i++) begin
                    regs_q[`RDATA_BASE + i] <= ld_word_i[i*`BYTE_BITS +: `BYTE_BITS];
                end
            end
            if (wr_en_i) begin
                regs_q[wr_ptr_i] <= wr_byte_i;   // Bus write wins on overlap
            end
            wr_done_o     <= wr_en_i;
            wr_done_ptr_o <= wr_ptr_i;
        end
    end

    assign rd_byte_o = regs_q[rd_ptr_i];
    assign regs_o    = regs_q;

endmodule

//--- logic/bus_bridge.sv
`timescale 1ns/10ps
`include "i2c_slave_defines.svh"

module bus_bridge
    import i2c_slave_pkg::*;
(
    input  logic                   Clk,
    input  logic                   Rst_n,
    input  byte_t [`REG_COUNT-1:0] regs_i,
    input  logic                   wr_done_i,
    input  reg_ptr_t               wr_done_ptr_i,
    input  word_t                  ahb_rdata_i,
    output word_t                  ahb_waddr_o,
    output word_t                  ahb_wdata_o,
    output word_t                  ahb_raddr_o,
    output logic                   w_valid_o,
    output logic                   r_valid_o,
    output logic                   ld_en_o,
    output word_t                  ld_word_o
);

    logic wr_hit;
    logic rd_hit;

    // Little-endian word from four registers, nibbles of each byte swapped
    function automatic word_t host_word(input byte_t [`REG_COUNT-1:0] r, input int base);
        word_t w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            w[i*`BYTE_BITS +: `BYTE_BITS] = {r[base + i][3:0], r[base + i][7:4]};
        end
        return w;
    endfunction

    // Last byte of the data field or of the read address field
    assign wr_hit = wr_done_i && (wr_done_ptr_i == reg_ptr_t'(`WDATA_BASE + 3));
    assign rd_hit = wr_done_i && (wr_done_ptr_i == reg_ptr_t'(`RDATA_BASE - 1));

    always_ff @(posedge Clk or negedge Rst_n) begin
        if (!Rst_n) begin
            ahb_waddr_o <= '0;
            ahb_wdata_o <= '0;
            ahb_raddr_o <= '0;
            w_valid_o   <= 1'b0;
            r_valid_o   <= 1'b0;
        end else begin
            w_valid_o <= wr_hit;
            r_valid_o <= rd_hit;
            if (wr_hit) begin
                ahb_waddr_o <= host_word(regs_i, `WADDR_BASE);
                ahb_wdata_o <= host_word(regs_i, `WDATA_BASE);
            end
            if (rd_hit) begin
                ahb_raddr_o <= host_word(regs_i, `RADDR_BASE);
            end
        end
    end

    // Read data lands in regs 12-15 during the strobe cycle
    assign ld_en_o   = r_valid_o;
    assign ld_word_o = ahb_rdata_i;

endmodule

//--- logic/i2c_ahb_slave_top.sv
`timescale 1ns/10ps
`include "i2c_slave_defines.svh"

module i2c_ahb_slave_top
    import i2c_slave_pkg::*;
(
    input  logic  Clk,
    input  logic  Rst_n,
    input  logic  scl_i,
    input  logic  sda_i,
    output logic  sda_oe_o,
    output logic  sda_o,
    output word_t ahb_waddr_o,
    output word_t ahb_wdata_o,
    output logic  w_valid_o,
    output word_t ahb_raddr_o,
    output logic  r_valid_o,
    input  word_t ahb_rdata_i
);

    logic                   scl_rise;
    logic                   scl_fall;
    logic                   scl_high;
    logic                   start_det;
    logic                   stop_det;
    logic                   sda_bit;
    logic                   wr_en;
    reg_ptr_t               wr_ptr;
    byte_t                  wr_byte;
    reg_ptr_t               rd_ptr;
    byte_t                  rd_byte;
    byte_t [`REG_COUNT-1:0] regs;
    logic                   wr_done;
    reg_ptr_t               wr_done_ptr;
    logic                   ld_en;
    word_t                  ld_word;

    i2c_line_monitor u_line_monitor (
        .Clk         (Clk),
        .Rst_n       (Rst_n),
        .scl_i       (scl_i),
        .sda_i       (sda_i),
        .scl_rise_o  (scl_rise),
        .scl_fall_o  (scl_fall),
        .scl_high_o  (scl_high),
        .start_det_o (start_det),
        .stop_det_o  (stop_det),
        .sda_bit_o   (sda_bit)
    );

    i2c_slave_fsm u_slave_fsm (
        .Clk         (Clk),
        .Rst_n       (Rst_n),
        .scl_rise_i  (scl_rise),
        .scl_fall_i  (scl_fall),
        .scl_high_i  (scl_high),
        .start_det_i (start_det),
        .stop_det_i  (stop_det),
        .sda_bit_i   (sda_bit),
        .rd_byte_i   (rd_byte),
        .sda_oe_o    (sda_oe_o),
        .sda_o       (sda_o),
        .wr_en_o     (wr_en),
        .wr_ptr_o    (wr_ptr),
        .wr_byte_o   (wr_byte),
        .rd_ptr_o    (rd_ptr)
    );

    slave_reg_file u_reg_file (
        .Clk           (Clk),
        .Rst_n         (Rst_n),
        .wr_en_i       (wr_en),
        .wr_ptr_i      (wr_ptr),
        .wr_byte_i     (wr_byte),
        .rd_ptr_i      (rd_ptr),
        .ld_en_i       (ld_en),
        .ld_word_i     (ld_word),
        .rd_byte_o     (rd_byte),
        .regs_o        (regs),
        .wr_done_o     (wr_done),
        .wr_done_ptr_o (wr_done_ptr)
    );

    bus_bridge u_bus_bridge (
        .Clk           (Clk),
        .Rst_n         (Rst_n),
        .regs_i        (regs),
        .wr_done_i     (wr_done),
        .wr_done_ptr_i (wr_done_ptr),
        .ahb_rdata_i   (ahb_rdata_i),
        .ahb_waddr_o   (ahb_waddr_o),
        .ahb_wdata_o   (ahb_wdata_o),
        .ahb_raddr_o   (ahb_raddr_o),
        .w_valid_o     (w_valid_o),
        .r_valid_o     (r_valid_o),
        .ld_en_o       (ld_en),
        .ld_word_o     (ld_word)
    );

endmodule

//--- test/i2c_ahb_slave_chk.sv
`timescale 1ns/10ps

module i2c_ahb_slave_chk (
    input logic Clk,
    input logic Rst_n,
    input logic scl_i,
    input logic sda_oe_i,
    input logic w_valid_i,
    input logic r_valid_i
);

    int fail_cnt = 0;   // Failed assertions so far

    w_pulse: assert property (@(posedge Clk) disable iff (!Rst_n) w_valid_i |=> !w_valid_i)
        else begin
            fail_cnt++;
            $error("w_valid_o high for more than one cycle");
        end

    r_pulse: assert property (@(posedge Clk) disable iff (!Rst_n) r_valid_i |=> !r_valid_i)
        else begin
            fail_cnt++;
            $error("r_valid_o high for more than one cycle");
        end

    one_strobe: assert property (@(posedge Clk) disable iff (!Rst_n) !(w_valid_i && r_valid_i))
        else begin
            fail_cnt++;
            $error("w_valid_o and r_valid_o high together");
        end

    // Slave may only move SDA while SCL is low
    oe_scl_low: assert property (@(posedge Clk) disable iff (!Rst_n) !$stable(sda_oe_i) |-> !scl_i)
        else begin
            fail_cnt++;
            $error("sda_oe_o changed while SCL was high");
        end

endmodule

bind i2c_ahb_slave_top i2c_ahb_slave_chk u_chk (
    .Clk       (Clk),
    .Rst_n     (Rst_n),
    .scl_i     (scl_i),
    .sda_oe_i  (sda_oe_o),
    .w_valid_i (w_valid_o),
    .r_valid_i (r_valid_o)
);

//--- test/tb_i2c_ahb_slave.sv
`timescale 1ns/10ps
`include "i2c_slave_defines.svh"

module tb_i2c_ahb_slave
    import i2c_slave_pkg::*;
();

    localparam int     CLK_NS      = 8;
    localparam int     BIT_CLKS    = 40;      // SCL period in system clocks
    localparam int     NUM_XFERS   = 14;
    localparam longint WATCHDOG_NS = 64'(NUM_XFERS) * 10 * 9 * BIT_CLKS * CLK_NS * 2;

    logic        Clk;
    logic        Rst_n;
    logic        scl_m;                       // Master SCL
    logic        sda_m;                       // Master SDA that releases the line when high
    logic        sda_line;
    logic        sda_oe;
    logic        sda_out;
    logic        w_valid;
    logic        r_valid;
    word_t       ahb_waddr;
    word_t       ahb_wdata;
    word_t       ahb_raddr;
    word_t       ahb_rdata;
    byte_t       model_regs [`REG_COUNT];
    reg_ptr_t    model_ptr;
    word_t       exp_waddr;
    word_t       exp_wdata;
    word_t       exp_raddr;
    int          w_cnt = 0;
    int          r_cnt = 0;
    int          exp_w_cnt = 0;
    int          exp_r_cnt = 0;
    logic [31:0] rng_state = 32'heb6d_da34;

    assign sda_line = sda_oe ? 1'b0 : sda_m;  // Open drain with pull-up

    i2c_ahb_slave_top u_i2c_ahb_slave_top (
        .Clk         (Clk),
        .Rst_n       (Rst_n),
        .scl_i       (scl_m),
        .sda_i       (sda_line),
        .sda_oe_o    (sda_oe),
        .sda_o       (sda_out),
        .ahb_waddr_o (ahb_waddr),
        .ahb_wdata_o (ahb_wdata),
        .w_valid_o   (w_valid),
        .ahb_raddr_o (ahb_raddr),
        .r_valid_o   (r_valid),
        .ahb_rdata_i (ahb_rdata)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_NS / 2) Clk = ~Clk;
    end

    always @(negedge Clk) begin
        if (w_valid) begin
            w_cnt++;
        end
        if (r_valid) begin
            r_cnt++;
        end
    end

    always @(negedge Clk) begin
        if (u_i2c_ahb_slave_top.u_chk.fail_cnt != 0) begin
            $display("bound checker reported an assertion failure");
            $display("TB FAILED");
            $fatal(1, "assertion failure");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected host word with byte i taken from register base+i and nibble-swapped
    function automatic word_t swapped_word(input int base);
        word_t w;
        byte_t b;
        w = '0;
        for (int i = 3; i >= 0; i--) begin
            b = model_regs[base + i];
            w = {w[23:0], b[3:0], b[7:4]};
        end
        return w;
    endfunction

    task automatic check_byte(input byte_t got, input byte_t exp, input string msg);
        if (got !== exp) begin
            $display("FAIL %0d ns: %s, got %02h expected %02h", $time, msg, got, exp);
            $display("TB FAILED");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        if (got !== exp) begin
            $display("FAIL %0d ns: %s, got %08h expected %08h", $time, msg, got, exp);
            $display("TB FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("FAIL %0d ns: %s, got %b expected %b", $time, msg, got, exp);
            $display("TB FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic wait_clks(input int n);
        repeat (n) @(posedge Clk);
        #1;
    endtask

    task automatic start_cond();
        sda_m = 1'b1;
        wait_clks(BIT_CLKS / 4);
        scl_m = 1'b1;
        wait_clks(BIT_CLKS / 4);
        sda_m = 1'b0;                 // SDA falls with SCL high
        wait_clks(BIT_CLKS / 4);
        scl_m = 1'b0;
        wait_clks(BIT_CLKS / 4);
    endtask

    task automatic stop_cond();
        sda_m = 1'b0;
        wait_clks(BIT_CLKS / 4);
        scl_m = 1'b1;
        wait_clks(BIT_CLKS / 4);
        sda_m = 1'b1;                 // SDA rises with SCL high
        wait_clks(BIT_CLKS / 2);
    endtask

    // One SCL period with the line sampled in the middle of SCL high
    task automatic clock_bit(input logic b, output logic s);
        sda_m = b;
        wait_clks(BIT_CLKS / 4);
        scl_m = 1'b1;
        wait_clks(BIT_CLKS / 4);
        s = sda_line;
        wait_clks(BIT_CLKS / 4);
        scl_m = 1'b0;
        wait_clks(BIT_CLKS / 4);
    endtask

    task automatic put_byte(input byte_t b, output logic ack);
        logic s;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(b[i], s);
        end
        clock_bit(1'b1, s);
        ack = ~s;
    endtask

    task automatic get_byte(input logic nack, input byte_t exp, output byte_t b,
                            output logic line);
        logic s;
        b = '0;
        for (int i = 7; i >= 0; i--) begin
            check_bit(sda_out, exp[i], "sda_o for a read bit");
            clock_bit(1'b1, s);
            b = {b[6:0], s};          // MSB first
        end
        clock_bit(nack, line);
    endtask

    task automatic model_store(input byte_t b);
        model_regs[model_ptr] = b;
        if (model_ptr == reg_ptr_t'(`WDATA_BASE + 3)) begin
            exp_w_cnt++;
            exp_waddr = swapped_word(`WADDR_BASE);
            exp_wdata = swapped_word(`WDATA_BASE);
        end
        if (model_ptr == reg_ptr_t'(`RADDR_BASE + 3)) begin
            exp_r_cnt++;
            exp_raddr = swapped_word(`RADDR_BASE);
            for (int i = 0; i < 4; i++) begin
                model_regs[`RDATA_BASE + i] = ahb_rdata[8*i +: 8];   // Low byte first without swap
            end
        end
        model_ptr++;
    endtask

    task automatic check_strobes();
        wait_clks(4);
        check_word(word_t'(w_cnt), word_t'(exp_w_cnt), "w_valid_o pulse count");
        check_word(word_t'(r_cnt), word_t'(exp_r_cnt), "r_valid_o pulse count");
        check_word(ahb_waddr, exp_waddr, "ahb_waddr_o");
        check_word(ahb_wdata, exp_wdata, "ahb_wdata_o");
        check_word(ahb_raddr, exp_raddr, "ahb_raddr_o");
    endtask

    // Only the low 4 bits of the pointer byte count so the upper nibble is random
    task automatic set_pointer(input reg_ptr_t ptr);
        logic        ack;
        logic [31:0] rnd;
        rnd = next_rand();
        put_byte({`I2C_DEV_ADDR, 1'b0}, ack);
        check_bit(ack, 1'b1, "address ACK for write");
        put_byte({rnd[7:4], ptr}, ack);
        check_bit(ack, 1'b1, "pointer ACK");
        model_ptr = ptr;
    endtask

    task automatic write_regs(input reg_ptr_t ptr, input byte_t data[$]);
        logic ack;
        start_cond();
        set_pointer(ptr);
        foreach (data[i]) begin
            put_byte(data[i], ack);
            check_bit(ack, 1'b1, "data ACK");
            model_store(data[i]);
        end
        stop_cond();
        check_strobes();
    endtask

    task automatic read_regs(input reg_ptr_t ptr, input int n);
        logic  ack;
        logic  line;
        byte_t got;
        start_cond();
        set_pointer(ptr);
        start_cond();                 // Repeated start
        put_byte({`I2C_DEV_ADDR, 1'b1}, ack);
        check_bit(ack, 1'b1, "address ACK for read");
        for (int i = 0; i < n; i++) begin
            get_byte(i == n - 1, model_regs[model_ptr], got, line);
            check_byte(got, model_regs[model_ptr], "read data");
            model_ptr++;
        end
        check_bit(line, 1'b1, "line released in master NACK slot");
        stop_cond();
        check_strobes();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before tests finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        byte_t       data_q[$];
        logic [31:0] rnd;
        logic [6:0]  bad_addr;
        logic        ack;
        reg_ptr_t    p;
        int          n;
        Rst_n     = 1'b0;
        scl_m     = 1'b1;
        sda_m     = 1'b1;
        ahb_rdata = '0;
        model_ptr = '0;
        exp_waddr = '0;
        exp_wdata = '0;
        exp_raddr = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge Clk);
        #1;
        Rst_n = 1'b1;
        wait_clks(5);
        check_bit(sda_oe, 1'b0, "sda_oe_o after reset");
        check_bit(sda_out, 1'b0, "sda_o after reset");
        check_strobes();

        // Writes that wrap past register 15 and their read-back
        repeat (3) begin
            p = reg_ptr_t'(12 + next_rand() % 4);
            n = int'(5 + next_rand() % 4);
            data_q.delete();
            repeat (n) data_q.push_back(byte_t'(next_rand()));
            write_regs(p, data_q);
            read_regs(p, n);
        end

        // Host write request through registers 0-7
        data_q.delete();
        repeat (8) data_q.push_back(byte_t'(next_rand()));
        write_regs(reg_ptr_t'(`WADDR_BASE), data_q);

        // Host read request that loads registers 12-15
        ahb_rdata = next_rand();
        data_q.delete();
        repeat (4) data_q.push_back(byte_t'(next_rand()));
        write_regs(reg_ptr_t'(`RADDR_BASE), data_q);
        read_regs(reg_ptr_t'(`RDATA_BASE), 4);

        // Foreign address is ignored
        bad_addr = 7'(next_rand());
        if (bad_addr == `I2C_DEV_ADDR) begin
            bad_addr = bad_addr ^ 7'h01;
        end
        rnd = next_rand();
        start_cond();
        put_byte({bad_addr, rnd[0]}, ack);
        check_bit(ack, 1'b0, "ACK slot for a foreign address");
        stop_cond();
        check_strobes();
        read_regs(4'd0, `REG_COUNT);

        // Read ended by NACK and the transfers after it
        read_regs(reg_ptr_t'(next_rand()), 3);
        check_bit(sda_oe, 1'b0, "sda_oe_o after a read ended by NACK");
        p = reg_ptr_t'(next_rand());
        data_q.delete();
        repeat (2) data_q.push_back(byte_t'(next_rand()));
        write_regs(p, data_q);
        read_regs(p, 2);

        if (u_i2c_ahb_slave_top.u_chk.fail_cnt != 0) begin
            $display("bound checker reported %0d assertion failures",
                     u_i2c_ahb_slave_top.u_chk.fail_cnt);
            $display("TB FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- sim.f
+incdir+logic
logic/i2c_slave_pkg.sv
logic/i2c_line_monitor.sv
logic/i2c_slave_fsm.sv
logic/slave_reg_file.sv
logic/bus_bridge.sv
logic/i2c_ahb_slave_top.sv
test/i2c_ahb_slave_chk.sv
test/tb_i2c_ahb_slave.sv

//--- Makefile
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tb_i2c_ahb_slave
RTL_TOP    := i2c_ahb_slave_top
FILELIST   := sim.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
